//--- tb.f
+incdir+.
icache_pkg.sv
icacheMemIf.sv
icacheMem.sv
icacheFill.sv
icacheAlign.sv
icache.sv
tb_icache_chk.sv
tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f tb.f -o tb_icache_sim

# The error limit lets the testbench report the first assertion failure itself
./obj_dir/tb_icache_sim +verilator+error+limit+1000

//--- tb_icache.sv
// Testbench for the instruction cache with a credited memory model and a random fetch stream
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int          numFetches = 400;
  localparam logic [31:0] seed       = 32'hda52_9e7c;

  logic  clk;
  logic  rstN;
  paddrT pcNext;
  paddrT pc;
  logic  stall;
  wordT  instrRaw;
  logic  compressed;
  logic  cacheStall;
  logic  memReq;
  paddrT memAdr;
  wordT  memRdData;
  logic  memRdValid;
  logic  memCreditReturn;

  logic [31:0] fetchRng;
  logic [31:0] memRng;
  int          fetchCount;
  int          cycle;

  // Outstanding memory answers, oldest first
  int   rspDue [$];
  wordT rspData [$];
  int   creditDue [$];

  icache dut0 (
    .clk             (clk),
    .rstN            (rstN),
    .pcNext          (pcNext),
    .pc              (pc),
    .stall           (stall),
    .instrRaw        (instrRaw),
    .compressed      (compressed),
    .cacheStall      (cacheStall),
    .memReq          (memReq),
    .memAdr          (memAdr),
    .memRdData       (memRdData),
    .memRdValid      (memRdValid),
    .memCreditReturn (memCreditReturn)
  );

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory holds A * golden ratio + A at word address A
  function automatic wordT memWord(input paddrT adr);
    logic [31:0] a;
    a = 32'(adr >> 2);
    return a * 32'h9e37_79b9 + a;
  endfunction

  // Mostly sequential, with jumps into a small window so lines get reused
  task automatic pickNextFetch(input paddrT cur, output paddrT nxt);
    fetchRng = lcgStep(fetchRng);
    case (fetchRng[31:29])
      3'd0:    nxt = {6'b0, fetchRng[9:1], 1'b0};
      3'd1:    nxt = cur ^ 16'h0100;
      3'd2:    nxt = {cur[15:4], 4'he};
      default: nxt = cur + 16'd2;
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Answers and credit returns come back 1 to 6 cycles after each request
  initial begin
    memRdData       = '0;
    memRdValid      = 1'b0;
    memCreditReturn = 1'b0;
    memRng          = lcgStep(seed);
    cycle           = 0;
    forever begin
      @(negedge clk);
      cycle++;
      memRdValid      = 1'b0;
      memCreditReturn = 1'b0;
      if (rspDue.size() != 0 && rspDue[0] <= cycle) begin
        memRdValid = 1'b1;
        memRdData  = rspData.pop_front();
        void'(rspDue.pop_front());
      end
      if (creditDue.size() != 0 && creditDue[0] <= cycle) begin
        memCreditReturn = 1'b1;
        void'(creditDue.pop_front());
      end
      #1;
      if (memReq) begin
        rspData.push_back(memWord(memAdr));
        memRng = lcgStep(memRng);
        rspDue.push_back(cycle + 1 + int'(memRng[31:16] % 16'd6));
        memRng = lcgStep(memRng);
        creditDue.push_back(cycle + 1 + int'(memRng[31:16] % 16'd6));
      end
    end
  end

  //////////////////////////////////////////////////
  // Fetch stream
  //////////////////////////////////////////////////

  initial begin
    logic  accepted;
    paddrT nxt;
    rstN       = 1'b0;
    pc         = '0;
    pcNext     = 16'h0040;
    stall      = 1'b0;
    fetchRng   = seed;
    fetchCount = 0;
    repeat (16) @(negedge clk);
    rstN = 1'b1;
    #1;
    accepted = !cacheStall;
    // A fetch moves on once the cache delivers it and fetch is not stalled
    do begin
      @(negedge clk);
      if (accepted && fetchCount < numFetches) begin
        pickNextFetch(pcNext, nxt);
        pc     = pcNext;
        pcNext = nxt;
        fetchCount++;
      end
      fetchRng = lcgStep(fetchRng);
      stall    = (fetchRng[31:28] == 4'd0);
      #1;
      accepted = !cacheStall && !stall;
    end while (!(accepted && fetchCount == numFetches));
    repeat (2) @(negedge clk);
    if (dut0.chk0.errCount == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "The checker reported an assertion failure");
    end
  end

  // The first checker failure ends the run
  always @(negedge clk) begin
    if (dut0.chk0.errCount != 0) begin
      $display("TEST FAILED");
      $fatal(1, "The checker reported an assertion failure");
    end
  end

  initial begin
    repeat (16 + 200 * numFetches) @(posedge clk);
    $display("TEST FAILED");
    $fatal(1, "Timeout, the fetch stream did not finish in %0d cycles", 16 + 200 * numFetches);
  end

endmodule

//--- tb_icache_chk.sv
// Concurrent checks on the instruction cache top, attached to every icache instance by bind
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_icache_chk (
  input logic               clk,
  input logic               rstN,
  input icache_pkg::paddrT  pc,
  input logic               stall,
  input icache_pkg::wordT   instrRaw,
  input logic               compressed,
  input logic               cacheStall,
  input logic               memReq,
  input icache_pkg::paddrT  memAdr,
  input logic               memCreditReturn
);
  import icache_pkg::*;

  // Number of failed assertions so far
  int unsigned errCount = 0;

  logic                         rstNQ = 1'b0;
  logic                         resetSeen = 1'b0;
  logic                         cacheStallQ;
  logic                         holdQ;
  logic                         live;
  logic                         resident;
  creditT                       outstanding;
  logic [2:0]                   reqCount;
  tagT                          shadowTag [`ICACHE_NUM_LINES];
  logic [`ICACHE_NUM_LINES-1:0] shadowValid;

  // Memory holds A * golden ratio + A at word address A
  function automatic wordT memWord(input paddrT adr);
    logic [31:0] a;
    a = 32'(adr >> 2);
    return a * 32'h9e37_79b9 + a;
  endfunction

  // Two halfwords starting at adr, nothing is taken from past the line end
  function automatic wordT expectInstr(input paddrT adr);
    wordT lo;
    wordT hi;
    lo = memWord(adr);
    hi = memWord(adr + 16'd4);
    if (adr[3:1] == 3'd7) begin
      return {16'h0000, lo[31:16]};
    end else if (adr[1]) begin
      return {hi[15:0], lo[31:16]};
    end
    return lo;
  endfunction

  // pc is only meaningful from the second cycle out of reset on
  assign live     = rstN & rstNQ;
  assign resident = shadowValid[pc[7:4]] & (shadowTag[pc[7:4]] == pc[15:8]);

  always @(posedge clk) begin
    rstNQ       <= rstN;
    cacheStallQ <= cacheStall;
    holdQ       <= live & stall & ~cacheStall;
    if (!rstN) begin
      resetSeen   <= 1'b1;
      outstanding <= '0;
      reqCount    <= '0;
      shadowValid <= '0;
    end else begin
      outstanding <= outstanding + creditT'(memReq) - creditT'(memCreditReturn);
      // Requests are counted per stall episode, and each episode is one line fill
      reqCount <= cacheStall ? reqCount + 3'(memReq) : 3'd0;
      // A delivered instruction means its line now sits in the array
      if (live && !cacheStall) begin
        shadowValid[pc[7:4]] <= 1'b1;
        shadowTag[pc[7:4]]   <= pc[15:8];
      end
    end
  end

  //////////////////////////////////////////////////
  // Fetch side
  //////////////////////////////////////////////////

  instrOk: assert property (@(posedge clk) live && !cacheStall |-> instrRaw == expectInstr(pc))
    else begin
      errCount++;
      $error("ERROR instrRaw got %h expected %h at pc %h", instrRaw, expectInstr(pc), pc);
    end

  lastHalfOk: assert property (@(posedge clk)
    live && !cacheStall && pc[3:1] == 3'd7 |-> instrRaw[31:16] == 16'h0000)
    else begin
      errCount++;
      $error("ERROR instrRaw upper half got %h expected 0000", instrRaw[31:16]);
    end

  // Only 32-bit encodings of the expected instruction have both low bits set
  compressedOk: assert property (@(posedge clk)
    live && !cacheStall |-> compressed == ((expectInstr(pc) & 32'h3) != 32'h3))
    else begin
      errCount++;
      $error("ERROR compressed got %h at pc %h", compressed, pc);
    end

  // A stalled fetch keeps its instruction
  holdOk: assert property (@(posedge clk) rstN && holdQ |-> $stable(instrRaw))
    else begin
      errCount++;
      $error("ERROR instrRaw got %h expected %h during stall", instrRaw, $past(instrRaw));
    end

  //////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////

  creditOk: assert property (@(posedge clk)
    rstN && memReq |-> outstanding != creditT'(`ICACHE_MEM_CREDITS))
    else begin
      errCount++;
      $error("Memory request issued with no credit left");
    end

  reqOnMissOk: assert property (@(posedge clk) rstN && memReq |-> cacheStall && !resident)
    else begin
      errCount++;
      $error("Memory request issued for a line that is already in the cache");
    end

  reqAdrOk: assert property (@(posedge clk)
    rstN && memReq |-> reqCount < 3'd4 && memAdr == {pc[15:4], reqCount[1:0], 2'b00})
    else begin
      errCount++;
      $error("ERROR memAdr got %h expected %h", memAdr, {pc[15:4], reqCount[1:0], 2'b00});
    end

  fillCountOk: assert property (@(posedge clk) live && !cacheStall && cacheStallQ |-> reqCount == 3'd4)
    else begin
      errCount++;
      $error("ERROR fill request count got %h expected 4", reqCount);
    end

  resetOk: assert property (@(posedge clk) resetSeen && !live |-> !memReq && !cacheStall)
    else begin
      errCount++;
      $error("memReq or cacheStall went high during reset or in the cycle after it");
    end

endmodule

bind icache tb_icache_chk chk0 (.*);

//--- icache.sv
// Top level of the instruction cache with plain fetch and memory ports
`timescale 1ns/1ps

module icache (
  input  logic               clk,
  input  logic               rstN,
  // Fetch side
  input  icache_pkg::paddrT  pcNext,
  input  icache_pkg::paddrT  pc,
  input  logic               stall,
  output icache_pkg::wordT   instrRaw,
  output logic               compressed,
  output logic               cacheStall,
  // Memory side
  output logic               memReq,
  output icache_pkg::paddrT  memAdr,
  input  icache_pkg::wordT   memRdData,
  input  logic               memRdValid,
  input  logic               memCreditReturn
);
  import icache_pkg::*;

  icacheMemIf memBus ();

  logic     reread;
  logic     hold;
  hwOffsetT hwOffset;

  // The array keeps its line while anything stalls fetch
  // The reread after a fill must get through regardless
  assign hold     = (stall | cacheStall) & ~reread;
  assign hwOffset = pc[1 +: $bits(hwOffsetT)];

  icacheMem mem0 (
    .clk    (clk),
    .rstN   (rstN),
    .pcNext (pcNext),
    .pc     (pc),
    .hold   (hold),
    .memIf  (memBus.mem)
  );

  icacheFill fill0 (
    .clk             (clk),
    .rstN            (rstN),
    .pc              (pc),
    .memIf           (memBus.fill),
    .cacheStall      (cacheStall),
    .reread          (reread),
    .memReq          (memReq),
    .memAdr          (memAdr),
    .memRdData       (memRdData),
    .memRdValid      (memRdValid),
    .memCreditReturn (memCreditReturn)
  );

  icacheAlign align0 (
    .readLine   (memBus.readLine),
    .hwOffset   (hwOffset),
    .instrRaw   (instrRaw),
    .compressed (compressed)
  );

endmodule

//--- icacheAlign.sv
// Picks the raw instruction out of a cache line at a halfword offset and flags compressed ones
`timescale 1ns/1ps

module icacheAlign (
  input  icache_pkg::lineT      readLine,
  input  icache_pkg::hwOffsetT  hwOffset,
  output icache_pkg::wordT      instrRaw,
  output logic                  compressed
);
  import icache_pkg::*;

  localparam int numHalves = $bits(lineT) / 16;

  // One extra zero halfword past the end of the line
  logic [15:0]              halves [numHalves+1];
  logic [$bits(hwOffsetT):0] upperSel;

  always_comb begin
    for (int i = 0; i < numHalves; i++) begin
      halves[i] = readLine[16*i +: 16];
    end
    halves[numHalves] = '0;
  end

  // One bit wider than the offset so the last halfword selects the zero pad
  assign upperSel = hwOffset + 1'b1;

  // An instruction in the last halfword gets zeros on top
  // The fetch unit takes care of the part that lives in the next line
  assign instrRaw = {halves[upperSel], halves[hwOffset]};

  // Only 32-bit encodings have both low bits set
  assign compressed = ~&instrRaw[1:0];

endmodule

//--- icacheFill.sv
// Miss FSM that fetches a line with credited word reads and writes it into the cache arrays
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheFill (
  input  logic               clk,
  input  logic               rstN,
  input  icache_pkg::paddrT  pc,
  icacheMemIf.fill           memIf,
  output logic               cacheStall,
  output logic               reread,
  output logic               memReq,
  output icache_pkg::paddrT  memAdr,
  input  icache_pkg::wordT   memRdData,
  input  logic               memRdValid,
  input  logic               memCreditReturn
);
  import icache_pkg::*;

  localparam int lineOffBits = $bits(hwOffsetT) + 1;

  fillStateT stateQ;
  fillStateT stateD;
  creditT    creditQ;
  wordSelT   issuedQ;
  wordSelT   receivedQ;
  lineT      lineQ;
  logic      primedQ;
  logic      rereadQ;
  logic      missDetect;
  logic      collecting;
  logic      lastIssue;
  logic      lastReceive;

  // The first cycle after reset has no array read behind it yet, so no miss is taken there
  // A stale hit during the reread cycle is ignored as well
  assign missDetect = primedQ & ~memIf.hit & ~rereadQ;

  // Responses may come back while later words are still being requested
  assign collecting = (stateQ == fillRequest) | (stateQ == fillWait);

  // One word per cycle as long as a credit is left
  assign memReq      = (stateQ == fillRequest) & (creditQ != '0);
  assign lastIssue   = memReq & (&issuedQ);
  assign lastReceive = collecting & memRdValid & (&receivedQ);

  // Words go out in address order starting at the line base
  assign memAdr = {pc[$bits(paddrT)-1:lineOffBits], issuedQ, 2'b00};

  //////////////////////////////////////////////////
  // Fill FSM
  //////////////////////////////////////////////////

  always_comb begin
    stateD = stateQ;
    unique case (stateQ)
      fillIdle: begin
        if (missDetect) begin
          stateD = fillRequest;
        end
      end
      fillRequest: begin
        if (lastIssue) begin
          stateD = fillWait;
        end
      end
      fillWait: begin
        if (lastReceive) begin
          stateD = fillWrite;
        end
      end
      fillWrite: begin
        stateD = fillIdle;
      end
      default: begin
        stateD = fillIdle;
      end
    endcase
  end

  // Counters wrap back to word 0, ready for the next fill
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stateQ    <= fillIdle;
      creditQ   <= creditT'(`ICACHE_MEM_CREDITS);
      issuedQ   <= '0;
      receivedQ <= '0;
      rereadQ   <= 1'b0;
      primedQ   <= 1'b0;
    end else begin
      stateQ  <= stateD;
      // A request and a return in the same cycle cancel out
      creditQ <= creditQ - creditT'(memReq) + creditT'(memCreditReturn);
      rereadQ <= (stateQ == fillWrite);
      primedQ <= 1'b1;
      if (memReq) begin
        issuedQ <= issuedQ + 1'b1;
      end
      if (collecting && memRdValid) begin
        receivedQ <= receivedQ + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Line assembly and write
  //////////////////////////////////////////////////

  // Memory answers in order, so the receive count is the word slot
  always_ff @(posedge clk) begin
    if (collecting && memRdValid) begin
      lineQ[{receivedQ, 5'b0} +: $bits(wordT)] <= memRdData;
    end
  end

  // Fetch holds pc for the whole miss, so pc names the line being filled
  assign memIf.writeEn    = (stateQ == fillWrite);
  assign memIf.writeIndex = pc[lineOffBits +: $bits(indexT)];
  assign memIf.writeTag   = pc[$bits(paddrT)-1 -: $bits(tagT)];
  assign memIf.writeLine  = lineQ;

  assign reread = rereadQ;

  // Stall covers the miss cycle itself, the whole fill and the reread
  assign cacheStall = (stateQ != fillIdle) | rereadQ | (primedQ & ~memIf.hit);

endmodule

//--- icacheMem.sv
// Tag, valid and data arrays of the direct-mapped cache with a registered read and the hit compare
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheMem (
  input  logic               clk,
  input  logic               rstN,
  input  icache_pkg::paddrT  pcNext,
  input  icache_pkg::paddrT  pc,
  input  logic               hold,
  icacheMemIf.mem            memIf
);
  import icache_pkg::*;

  // Byte offset bits inside a line sit below the index
  localparam int lineOffBits = $bits(hwOffsetT) + 1;

  tagT                          tagArr [`ICACHE_NUM_LINES];
  lineT                         dataArr [`ICACHE_NUM_LINES];
  logic [`ICACHE_NUM_LINES-1:0] validArr;

  indexT pcIdx;
  tagT   pcTag;
  indexT readIdx;
  indexT readIdxQ;
  tagT   readTagQ;
  lineT  readLineQ;
  logic  readValidQ;
  logic  writtenQ;

  // Fields of the address now in fetch
  assign pcIdx = pc[lineOffBits +: $bits(indexT)];
  assign pcTag = pc[$bits(paddrT)-1 -: $bits(tagT)];

  // Normally the array looks one cycle ahead at pcNext
  // Right after a line write it rereads the line of pc, whatever the fetch side shows as next
  assign readIdx = writtenQ ? pcIdx : pcNext[lineOffBits +: $bits(indexT)];

  //////////////////////////////////////////////////
  // Array writes
  //////////////////////////////////////////////////

  // Valid bits start cleared and are only ever set by a fill
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validArr <= '0;
    end else if (memIf.writeEn) begin
      validArr[memIf.writeIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (memIf.writeEn) begin
      tagArr[memIf.writeIndex]  <= memIf.writeTag;
      dataArr[memIf.writeIndex] <= memIf.writeLine;
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // Hold keeps the read registers so the output line stays put during a stall
  always_ff @(posedge clk) begin
    if (!rstN) begin
      readValidQ <= 1'b0;
      writtenQ   <= 1'b0;
    end else begin
      writtenQ <= memIf.writeEn;
      if (!hold) begin
        readValidQ <= validArr[readIdx];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      readIdxQ  <= readIdx;
      readTagQ  <= tagArr[readIdx];
      readLineQ <= dataArr[readIdx];
    end
  end

  // The index compare catches a read that was taken at some other line than pc
  assign memIf.hit      = readValidQ & (readTagQ == pcTag) & (readIdxQ == pcIdx);
  assign memIf.readLine = readLineQ;

endmodule

//--- icacheMemIf.sv
// Line write and hit result between the fill controller and the cache arrays
`timescale 1ns/1ps

interface icacheMemIf;
  import icache_pkg::*;

  // Write port of the arrays, owned by the fill controller
  logic  writeEn;
  indexT writeIndex;
  tagT   writeTag;
  lineT  writeLine;

  // Read side of the arrays
  // Hit compares against the current fetch address
  logic  hit;
  lineT  readLine;

  // The fill controller writes lines and watches the hit to know when to fill
  modport fill (
    output writeEn,
    output writeIndex,
    output writeTag,
    output writeLine,
    input  hit
  );

  // The arrays take the write and report what they read
  modport mem (
    input  writeEn,
    input  writeIndex,
    input  writeTag,
    input  writeLine,
    output hit,
    output readLine
  );

endinterface

//--- icache_pkg.sv
// Shared types of the instruction cache, imported by every RTL module and the testbench
`include "icache_settings.svh"

package icache_pkg;

  //////////////////////////////////////////////////
  // Address fields
  //////////////////////////////////////////////////

  // Physical fetch address
  typedef logic [`ICACHE_PA_BITS-1:0] paddrT;

  // Line number inside the array, address bits just above the line offset
  typedef logic [$clog2(`ICACHE_NUM_LINES)-1:0] indexT;

  // Everything above the index is tag
  typedef logic [`ICACHE_PA_BITS-$clog2(`ICACHE_NUM_LINES)-$clog2(`ICACHE_LINE_BITS/8)-1:0] tagT;

  // Halfword position of an instruction inside its line
  typedef logic [$clog2(`ICACHE_LINE_BITS/16)-1:0] hwOffsetT;

  // Word position inside a line, used to order the fill requests
  typedef logic [$clog2(`ICACHE_LINE_BITS/32)-1:0] wordSelT;

  //////////////////////////////////////////////////
  // Data and control
  //////////////////////////////////////////////////

  // A memory word and also a raw instruction
  typedef logic [31:0] wordT;

  // A whole cache line
  typedef logic [`ICACHE_LINE_BITS-1:0] lineT;

  // Credit count with headroom above the reset value
  typedef logic [2:0] creditT;

  // Line fill FSM
  typedef enum logic [1:0] {
    fillIdle,
    fillRequest,
    fillWait,
    fillWrite
  } fillStateT;

endpackage

//--- icache_settings.svh
// Size and flow-control settings for the instruction cache, included by the package and the RTL
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

//////////////////////////////////////////////////
// Address and geometry
//////////////////////////////////////////////////

// Physical address width of the fetch stage
`define ICACHE_PA_BITS 16

// One line holds four 32-bit words
`define ICACHE_LINE_BITS 128

// Direct mapped, so this is also the number of sets
`define ICACHE_NUM_LINES 16

//////////////////////////////////////////////////
// Memory flow control
//////////////////////////////////////////////////

// Requests that may be outstanding before memory returns a credit
`define ICACHE_MEM_CREDITS 2

`endif
